/* src/cpu_pkg.sv */
package cpu_pkg;

localparam int XLEN = 32;
localparam logic [XLEN-1:0] RESET_PC = '0;
localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0

typedef enum logic [6:0] {
	OPC_LUI    = 7'b0110111,
	OPC_AUIPC  = 7'b0010111,
	OPC_JAL    = 7'b1101111,
	OPC_JALR   = 7'b1100111,
	OPC_BRANCH = 7'b1100011,
	OPC_LOAD   = 7'b0000011,
	OPC_STORE  = 7'b0100011,
	OPC_OP_IMM = 7'b0010011,
	OPC_OP     = 7'b0110011
} opcode_e;

typedef enum logic [3:0] {
	ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
	ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
} alu_op_e;

typedef struct packed {
	alu_op_e    alu_op;
	logic       sel_pc;    // operand a is pc
	logic       sel_imm;   // operand b is imm
	logic       jump;
	logic       jalr;
	logic       branch;
	logic [2:0] funct3;
	logic       load;
	logic       store;
	logic       reg_write;
} ctrl_t;

typedef struct packed {
	logic [XLEN-1:0] pc;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [4:0]      rd;
	logic [XLEN-1:0] imm;
	ctrl_t           ctrl;
} id_ex_t;

typedef struct packed {
	logic [4:0]      rd;
	logic [XLEN-1:0] result;    // alu value or link address
	logic [XLEN-1:0] store_val;
	logic [2:0]      funct3;
	logic            load;
	logic            store;
	logic            reg_write;
} ex_mem_t;

endpackage

/* src/fetch.sv */
module fetch import cpu_pkg::*; (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic [XLEN-1:0] inst_i,
	input  logic            pc_pause_i,
	input  logic            if_id_pause_i,
	input  logic            if_id_bubble_i,
	input  logic            redirect_i,
	input  logic [XLEN-1:0] target_i,
	output logic [XLEN-1:0] pc_o,
	output logic [XLEN-1:0] id_pc_o,
	output logic [XLEN-1:0] id_inst_o
);

logic [XLEN-1:0] npc;

always_comb begin
	if (redirect_i)
		npc = target_i; // taken branch or jump from ex
	else if (pc_pause_i)
		npc = pc_o;
	else
		npc = pc_o + XLEN'(4);
end

always_ff @(posedge clk_i or negedge arst_n_i) begin
	if (!arst_n_i)
		pc_o <= RESET_PC;
	else
		pc_o <= npc;
end

// if/id register
always_ff @(posedge clk_i or negedge arst_n_i) begin
	if (!arst_n_i) begin
		id_pc_o   <= RESET_PC;
		id_inst_o <= NOP_INST;
	end else if (if_id_bubble_i) begin
		id_inst_o <= NOP_INST; // squashed slot
	end else if (!if_id_pause_i) begin
		id_pc_o   <= pc_o;
		id_inst_o <= inst_i;
	end
end

pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i) pc_o[1:0] == 2'b00)
	else $error("fetch: pc %h not word aligned", pc_o);

endmodule

/* src/decoder.sv */
module decoder import cpu_pkg::*; (
	input  logic [XLEN-1:0] inst_i,
	output logic [4:0]      rs1_o,
	output logic [4:0]      rs2_o,
	output logic [4:0]      rd_o,
	output logic [XLEN-1:0] imm_o,
	output ctrl_t           ctrl_o
);

opcode_e    opc;
logic [2:0] f3;
logic [6:0] f7;
logic       f7_zero, f7_alt;

assign opc     = opcode_e'(inst_i[6:0]);
assign f3      = inst_i[14:12];
assign f7      = inst_i[31:25];
assign f7_zero = f7 == 7'b0000000;
assign f7_alt  = f7 == 7'b0100000; // sub / sra / srai

assign rs1_o = inst_i[19:15];
assign rs2_o = inst_i[24:20];
assign rd_o  = inst_i[11:7];

function automatic alu_op_e alu_map(input logic [2:0] fn, input logic alt);
	case (fn)
		3'b000:  return alt ? ALU_SUB : ALU_ADD;
		3'b001:  return ALU_SLL;
		3'b010:  return ALU_SLT;
		3'b011:  return ALU_SLTU;
		3'b100:  return ALU_XOR;
		3'b101:  return alt ? ALU_SRA : ALU_SRL;
		3'b110:  return ALU_OR;
		default: return ALU_AND;
	endcase
endfunction

always_comb begin
	ctrl_o = '0;
	imm_o  = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]}; // i-type by default
	case (opc)
		OPC_LUI, OPC_AUIPC: begin
			imm_o            = {inst_i[31:12], 12'b0};
			ctrl_o.alu_op    = (opc == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
			ctrl_o.sel_pc    = opc == OPC_AUIPC;
			ctrl_o.sel_imm   = 1'b1;
			ctrl_o.reg_write = 1'b1;
		end
		OPC_JAL: begin
			imm_o = {{(XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
			ctrl_o.jump      = 1'b1;
			ctrl_o.reg_write = 1'b1;
		end
		OPC_JALR: begin
			ctrl_o.sel_imm   = 1'b1;
			ctrl_o.jump      = 1'b1;
			ctrl_o.jalr      = 1'b1;
			ctrl_o.reg_write = 1'b1;
		end
		OPC_BRANCH: begin
			imm_o = {{(XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
			ctrl_o.branch = f3[2:1] != 2'b01; // 010/011 not defined
			ctrl_o.funct3 = f3;
		end
		OPC_LOAD: begin
			ctrl_o.sel_imm   = 1'b1;
			ctrl_o.funct3    = f3;
			ctrl_o.load      = f3 != 3'b011 && f3[2:1] != 2'b11;
			ctrl_o.reg_write = ctrl_o.load;
		end
		OPC_STORE: begin
			imm_o          = {{(XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
			ctrl_o.sel_imm = 1'b1;
			ctrl_o.funct3  = f3;
			ctrl_o.store   = !f3[2] && f3[1:0] != 2'b11;
		end
		OPC_OP_IMM: begin
			ctrl_o.alu_op  = alu_map(f3, f3 == 3'b101 && inst_i[30]);
			ctrl_o.sel_imm = 1'b1;
			// shift immediates only take the two legal funct7 forms
			ctrl_o.reg_write = f3[1:0] != 2'b01 || f7_zero || (f3 == 3'b101 && f7_alt);
		end
		OPC_OP: begin
			ctrl_o.alu_op    = alu_map(f3, inst_i[30]);
			ctrl_o.reg_write = f7_zero || (f7_alt && (f3 == 3'b000 || f3 == 3'b101));
		end
		default: ; // ecall, fence, csr and friends run as no-ops
	endcase
end

endmodule

/* src/gpr.sv */
module gpr import cpu_pkg::*; (
	input  logic            clk_i,
	input  logic [4:0]      rs1_i,
	input  logic [4:0]      rs2_i,
	input  logic [4:0]      rd_i,
	input  logic            we_i,
	input  logic [XLEN-1:0] wdata_i,
	output logic [XLEN-1:0] rdata1_o,
	output logic [XLEN-1:0] rdata2_o
);

logic [XLEN-1:0] regs [1:31]; // no storage for x0
logic            wr_en;

assign wr_en = we_i && rd_i != 5'd0;

always_ff @(posedge clk_i) begin
	if (wr_en)
		regs[rd_i] <= wdata_i;
end

function automatic logic [XLEN-1:0] read_port(input logic [4:0] idx);
	if (idx == 5'd0)
		return '0;
	if (wr_en && idx == rd_i)
		return wdata_i; // write-first
	return regs[idx];
endfunction

always_comb begin
	rdata1_o = read_port(rs1_i);
	rdata2_o = read_port(rs2_i);
end

endmodule

/* src/alu.sv */
module alu import cpu_pkg::*; (
	input  alu_op_e         op_i,
	input  logic [XLEN-1:0] a_i,
	input  logic [XLEN-1:0] b_i,
	output logic [XLEN-1:0] y_o,
	output logic            eq_o,
	output logic            lt_o,
	output logic            ltu_o
);

logic [4:0] shamt;

assign shamt = b_i[4:0];

// compare results double as branch conditions
assign eq_o  = a_i == b_i;
assign lt_o  = $signed(a_i) < $signed(b_i);
assign ltu_o = a_i < b_i;

always_comb begin
	case (op_i)
		ALU_ADD:    y_o = a_i + b_i;
		ALU_SUB:    y_o = a_i - b_i;
		ALU_SLL:    y_o = a_i << shamt;
		ALU_SLT:    y_o = {{(XLEN-1){1'b0}}, lt_o};
		ALU_SLTU:   y_o = {{(XLEN-1){1'b0}}, ltu_o};
		ALU_XOR:    y_o = a_i ^ b_i;
		ALU_SRL:    y_o = a_i >> shamt;
		ALU_SRA:    y_o = $unsigned($signed(a_i) >>> shamt);
		ALU_OR:     y_o = a_i | b_i;
		ALU_AND:    y_o = a_i & b_i;
		ALU_PASS_B: y_o = b_i; // lui
		default:    y_o = '0;
	endcase
end

endmodule

/* src/execute.sv */
module execute import cpu_pkg::*; (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  id_ex_t          id_i,
	input  logic            bubble_i,
	input  logic [4:0]      mem_rd_i,
	input  logic [XLEN-1:0] mem_fwd_i,
	output ctrl_t           ex_ctrl_o,
	output logic [4:0]      ex_rd_o,
	output logic            redirect_o,
	output logic [XLEN-1:0] target_o,
	output ex_mem_t         mem_o
);

id_ex_t          id_ex_q;
logic [XLEN-1:0] fwd_a, fwd_b;
logic [XLEN-1:0] op_a, op_b, alu_y;
logic            eq, lt, ltu, take;
logic            fwd_ok;

// id/ex register
always_ff @(posedge clk_i or negedge arst_n_i) begin
	if (!arst_n_i) begin
		id_ex_q <= '0;
	end else begin
		id_ex_q <= id_i;
		if (bubble_i)
			id_ex_q.ctrl <= '0;
	end
end

assign ex_ctrl_o = id_ex_q.ctrl;
assign ex_rd_o   = id_ex_q.rd;

// mem stage result, load data included
assign fwd_ok = mem_o.reg_write && mem_rd_i != 5'd0;
assign fwd_a  = (fwd_ok && mem_rd_i == id_ex_q.rs1) ? mem_fwd_i : id_ex_q.rs1_val;
assign fwd_b  = (fwd_ok && mem_rd_i == id_ex_q.rs2) ? mem_fwd_i : id_ex_q.rs2_val;

assign op_a = id_ex_q.ctrl.sel_pc ? id_ex_q.pc : fwd_a;
assign op_b = id_ex_q.ctrl.sel_imm ? id_ex_q.imm : fwd_b;

alu alu_inst (
	.op_i (id_ex_q.ctrl.alu_op),
	.a_i  (op_a),
	.b_i  (op_b),
	.y_o  (alu_y),
	.eq_o (eq),
	.lt_o (lt),
	.ltu_o(ltu)
);

always_comb begin
	case (id_ex_q.ctrl.funct3)
		3'b000:  take = eq;
		3'b001:  take = !eq;
		3'b100:  take = lt;
		3'b101:  take = !lt;
		3'b110:  take = ltu;
		3'b111:  take = !ltu;
		default: take = 1'b0;
	endcase
end

assign redirect_o = id_ex_q.ctrl.jump || (id_ex_q.ctrl.branch && take);
assign target_o   = id_ex_q.ctrl.jalr ? {alu_y[XLEN-1:1], 1'b0} : id_ex_q.pc + id_ex_q.imm;

// ex/mem register
always_ff @(posedge clk_i or negedge arst_n_i) begin
	if (!arst_n_i) begin
		mem_o <= '0;
	end else begin
		mem_o.rd        <= id_ex_q.rd;
		mem_o.result    <= id_ex_q.ctrl.jump ? id_ex_q.pc + XLEN'(4) : alu_y; // link
		mem_o.store_val <= fwd_b;
		mem_o.funct3    <= id_ex_q.ctrl.funct3;
		mem_o.load      <= id_ex_q.ctrl.load;
		mem_o.store     <= id_ex_q.ctrl.store;
		mem_o.reg_write <= id_ex_q.ctrl.reg_write;
	end
end

no_ld_st: assert property (@(posedge clk_i) disable iff (!arst_n_i) !(mem_o.load && mem_o.store))
	else $error("execute: load and store both set in ex/mem");

endmodule

/* src/lsu.sv */
module lsu import cpu_pkg::*; (
	input  ex_mem_t         mem_i,
	input  logic [XLEN-1:0] load_data_i,
	output logic [XLEN-1:0] store_data_o,
	output logic [XLEN-1:0] wb_data_o
);

logic [1:0]      ofs;
logic [7:0]      ld_byte;
logic [15:0]     ld_half;
logic [XLEN-1:0] ld_val;

assign ofs     = mem_i.result[1:0];
assign ld_byte = load_data_i[{ofs, 3'b000} +: 8];
assign ld_half = load_data_i[{ofs[1], 4'b0000} +: 16];

always_comb begin
	case (mem_i.funct3)
		3'b000:  ld_val = {{(XLEN-8){ld_byte[7]}}, ld_byte};   // lb
		3'b001:  ld_val = {{(XLEN-16){ld_half[15]}}, ld_half}; // lh
		3'b100:  ld_val = {{(XLEN-8){1'b0}}, ld_byte};
		3'b101:  ld_val = {{(XLEN-16){1'b0}}, ld_half};
		default: ld_val = load_data_i;
	endcase
end

// sub-word stores rewrite only their lanes of the current word
always_comb begin
	store_data_o = load_data_i;
	case (mem_i.funct3[1:0])
		2'b00:   store_data_o[{ofs, 3'b000} +: 8] = mem_i.store_val[7:0];
		2'b01:   store_data_o[{ofs[1], 4'b0000} +: 16] = mem_i.store_val[15:0];
		default: store_data_o = mem_i.store_val;
	endcase
end

assign wb_data_o = mem_i.load ? ld_val : mem_i.result;

endmodule

/* src/hazard.sv */
module hazard import cpu_pkg::*; (
	input  ctrl_t      ex_ctrl_i,
	input  logic [4:0] ex_rd_i,
	input  logic [4:0] id_rs1_i,
	input  logic [4:0] id_rs2_i,
	input  logic       redirect_i,
	output logic       pc_pause_o,
	output logic       if_id_pause_o,
	output logic       if_id_bubble_o,
	output logic       id_ex_bubble_o
);

logic load_use;
logic stall;

// load in ex feeding the instruction in decode
assign load_use = ex_ctrl_i.load && ex_rd_i != 5'd0
	&& (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

assign stall = load_use && !redirect_i; // redirect wins

assign pc_pause_o     = stall;
assign if_id_pause_o  = stall;
assign if_id_bubble_o = redirect_i;
assign id_ex_bubble_o = stall || redirect_i;

always_comb begin
	assert (!(if_id_pause_o && if_id_bubble_o))
		else $error("hazard: if/id paused and bubbled together");
end

endmodule

/* src/cpu.sv */
module cpu import cpu_pkg::*; (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic [XLEN-1:0] inst_i,
	input  logic [XLEN-1:0] load_data_i,
	output logic [XLEN-1:0] pc_o,
	output logic [XLEN-1:0] address_o,
	output logic [XLEN-1:0] store_data_o,
	output logic            mem_load_o,
	output logic            mem_store_o
);

logic [XLEN-1:0] id_pc, id_inst, id_imm;
logic [XLEN-1:0] id_rs1_val, id_rs2_val;
logic [4:0]      rs1, rs2, rd, ex_rd;
ctrl_t           id_ctrl, ex_ctrl;
id_ex_t          id_pkt;
ex_mem_t         mem;
logic            pc_pause, if_id_pause, if_id_bubble, id_ex_bubble;
logic            redirect;
logic [XLEN-1:0] target, wb_data;

// stage IF
fetch fetch_inst (
	.clk_i(clk_i), .arst_n_i(arst_n_i), .inst_i(inst_i),
	.pc_pause_i(pc_pause), .if_id_pause_i(if_id_pause), .if_id_bubble_i(if_id_bubble),
	.redirect_i(redirect), .target_i(target),
	.pc_o(pc_o), .id_pc_o(id_pc), .id_inst_o(id_inst)
);

// stage ID
decoder decoder_inst (
	.inst_i(id_inst), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(id_imm), .ctrl_o(id_ctrl)
);

gpr gpr_inst (
	.clk_i(clk_i), .rs1_i(rs1), .rs2_i(rs2),
	.rd_i(mem.rd), .we_i(mem.reg_write), .wdata_i(wb_data),
	.rdata1_o(id_rs1_val), .rdata2_o(id_rs2_val)
);

hazard hazard_inst (
	.ex_ctrl_i(ex_ctrl), .ex_rd_i(ex_rd), .id_rs1_i(rs1), .id_rs2_i(rs2), .redirect_i(redirect),
	.pc_pause_o(pc_pause), .if_id_pause_o(if_id_pause),
	.if_id_bubble_o(if_id_bubble), .id_ex_bubble_o(id_ex_bubble)
);

assign id_pkt = '{pc: id_pc, rs1: rs1, rs2: rs2, rs1_val: id_rs1_val, rs2_val: id_rs2_val,
	rd: rd, imm: id_imm, ctrl: id_ctrl};

// stage EX
execute execute_inst (
	.clk_i(clk_i), .arst_n_i(arst_n_i), .id_i(id_pkt), .bubble_i(id_ex_bubble),
	.mem_rd_i(mem.rd), .mem_fwd_i(wb_data),
	.ex_ctrl_o(ex_ctrl), .ex_rd_o(ex_rd), .redirect_o(redirect), .target_o(target), .mem_o(mem)
);

// stage MEM/WB
assign address_o   = mem.result;
assign mem_load_o  = mem.load;
assign mem_store_o = mem.store;

lsu lsu_inst (
	.mem_i(mem), .load_data_i(load_data_i), .store_data_o(store_data_o), .wb_data_o(wb_data)
);

endmodule

/* tests/tb_cpu.sv */
module tb_cpu;
timeunit 1ns;
timeprecision 100ps;

logic        clk, arst_n;
logic [31:0] inst, load_data;
logic [31:0] pc, address, store_data;
logic        mem_load, mem_store;

logic [31:0] gold [0:255];
logic [31:0] imem [0:1023];
logic [31:0] dmem [0:1023];
int          n_inst, n_data, n_store, rec_base, rec_idx, errors, cycles;
bit          finished, wr_pend;
logic [31:0] wr_addr, wr_data, exp_addr, exp_data;

always #2 clk = ~clk;

// combinational memories
assign inst      = imem[pc[11:2]];
assign load_data = dmem[address[11:2]];

cpu u_dut (
	.clk_i(clk), .arst_n_i(arst_n), .inst_i(inst), .load_data_i(load_data),
	.pc_o(pc), .address_o(address), .store_data_o(store_data),
	.mem_load_o(mem_load), .mem_store_o(mem_store)
);

task automatic check_idle();
	if (mem_store !== 1'b0) begin
		errors++;
		$display("FAIL %0t mem_store_o got %b expected %b", $time, mem_store, 1'b0);
	end
	if (mem_load !== 1'b0) begin
		errors++;
		$display("FAIL %0t mem_load_o got %b expected %b", $time, mem_load, 1'b0);
	end
	if (pc !== 32'h0) begin
		errors++;
		$display("FAIL %0t pc_o got %h expected %h", $time, pc, 32'h0);
	end
endtask

// stores are checked mid-cycle, written at the next rising edge
always @(negedge clk) begin
	if (arst_n && mem_store) begin
		if (rec_idx >= n_store) begin
			errors++;
			$display("unexpected extra store to %h at %0t", address, $time);
		end else begin
			exp_addr = gold[rec_base + 2 * rec_idx];
			exp_data = gold[rec_base + 2 * rec_idx + 1];
			if (address !== exp_addr) begin
				errors++;
				$display("FAIL %0t address_o got %h expected %h", $time, address, exp_addr);
			end
			if (store_data !== exp_data) begin
				errors++;
				$display("FAIL %0t store_data_o got %h expected %h", $time, store_data, exp_data);
			end
			rec_idx++;
		end
		wr_pend = 1'b1;
		wr_addr = address;
		wr_data = store_data;
		if (address == 32'hffc)
			finished = 1'b1;
	end
end

always @(posedge clk) begin
	if (wr_pend) begin
		dmem[wr_addr[11:2]] <= wr_data;
		wr_pend = 1'b0;
	end
end

initial begin
	clk = 1'b0;
	arst_n = 1'b0;
	errors = 0;
	rec_idx = 0;
	finished = 1'b0;
	wr_pend = 1'b0;
	for (int i = 0; i < 1024; i++) begin
		imem[i] = 32'(i) << 7; // opcode field zero, runs as no-op
		dmem[i] = 32'(i) * 32'h9e37_79b1;
	end
	$readmemh("tests/cpu_golden.txt", gold);
	n_inst   = gold[0];
	n_data   = gold[1];
	n_store  = gold[2];
	rec_base = 4 + n_inst + n_data;
	for (int i = 0; i < n_inst; i++)
		imem[i] = gold[4 + i];
	for (int i = 0; i < n_data; i++)
		dmem[gold[3][11:2] + i] = gold[4 + n_inst + i];

	repeat (4) begin
		@(negedge clk);
		check_idle();
	end
	@(posedge clk);
	#0.5 arst_n = 1'b1;
	@(negedge clk);
	check_idle();

	cycles = 0;
	while (!finished && cycles < 2000) begin
		@(posedge clk);
		cycles++;
	end
	if (!finished) begin
		errors++;
		$display("timeout: no store to the finish address within 2000 cycles");
	end else if (rec_idx != n_store) begin
		errors++;
		$display("missing stores: only %0d of %0d seen", rec_idx, n_store);
	end
	$display("%0d errors, %0d of %0d stores checked", errors, rec_idx, n_store);
	if (errors == 0)
		$display("Done: no errors");
	else
		$display("Done: errors found");
	$finish;
end

endmodule

/* tests/cpu_golden.txt */
// header: instruction count, data word count, store record count, data base address
// then program words from address 0, data words from the base, store records (address word)
00000031 00000002 0000000f 00000200
// 0x00: alu ops and forwarding
20000513 30000593 ff900093 00300113 002081b3 0035a023 40110233 0045a223
4020d2b3 01c0d313 0020a3b3 0020b433 0062c4b3 0074e4b3 008484b3 0095a423
// 0x40: lui, auipc, loads with their consumers right behind
12345637 00001697 67866713 00e5a623 00d5a823 00150783 00178793 00f5aa23
00255803 0105ac23 00251883 00054903 012889b3 0135ae23 001502a3 00e51323
// 0x80: merged word, branches, jal, jalr, finish store, self loop
00452a03 0345a023 00208463 0225a223 0020c663 0205a423 0205a623 00c00aef
0205a823 0205aa23 0355ac23 014a8b67 0205ae23 0565a023 7fe00b93 7e4baf23
0000006f
// data at 0x200
8081f0f2 11223344
// expected stores in program order
00000300 fffffffc  00000304 0000000a  00000308 fffffff1
0000030c 12345678  00000310 00001044  00000314 fffffff1
00000318 00008081  0000031c ffff8173  00000205 1122f944
00000206 5678f944  00000320 5678f944  00000324 00000003
00000338 000000a0  00000340 000000b0  00000ffc 0000000a

/* project.f */
src/cpu_pkg.sv
src/fetch.sv
src/decoder.sv
src/gpr.sv
src/alu.sv
src/execute.sv
src/lsu.sv
src/hazard.sv
src/cpu.sv
tests/tb_cpu.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu
FILELIST = project.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
